/* filelist.f */
verilog/cart_pkg.sv
verilog/c64_bus_pkg.sv
verilog/cart_bank_table.sv
verilog/cart_io_decode.sv
verilog/cart_ctrl_regs.sv
verilog/cart_addr_xlate.sv
verilog/cartridge.sv
test/tb_clock.sv
test/tb_cartridge.sv

/* Makefile */
# Verilator lint, simulation and cleanup for the cartridge testbench
TOP := tb_cartridge

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_cartridge.sv */
// Cartridge testbench with random stimulus, page table and control model, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_cartridge;

	localparam int N_CHUNKS        = 24;
	localparam int N_IO            = 24;
	localparam int N_OPS           = 64 + N_CHUNKS + 4 * N_IO + 16;
	localparam int WATCHDOG_CYCLES = N_OPS * 20 + 1000;

	logic                     clk32;
	logic                     reset_n;
	logic                     cart_loading;
	cart_pkg::cart_type_e     cart_id;
	logic                     cart_exrom;
	logic                     cart_game;
	cart_pkg::cart_chunk_t    cart_chunk;
	logic                     cart_bank_wr;
	c64_bus_pkg::c64_bus_t    bus;
	logic                     exrom;
	logic                     game;
	logic                     mem_ce_out;
	logic                     mem_write_out;
	c64_bus_pkg::sdram_addr_t addr_out;
	cart_pkg::bank_t          bank_lo;
	cart_pkg::bank_t          bank_hi;

	// **************************************************
	// Reference model state
	// **************************************************
	logic [6:0] lo_tab [64];
	logic [6:0] hi_tab [64];
	logic       m_exrom;
	logic       m_game;
	logic [6:0] m_lo;
	logic [6:0] m_hi;

	tb_clock u_clock (.clk32(clk32), .reset_n(reset_n));

	cartridge #(.BANK_SLOTS(64)) dut (
		.clk32(clk32), .reset_n(reset_n), .cart_loading(cart_loading), .cart_id(cart_id),
		.cart_exrom(cart_exrom), .cart_game(cart_game), .cart_chunk(cart_chunk),
		.cart_bank_wr(cart_bank_wr), .bus(bus), .exrom(exrom), .game(game),
		.mem_ce_out(mem_ce_out), .mem_write_out(mem_write_out), .addr_out(addr_out),
		.bank_lo(bank_lo), .bank_hi(bank_hi)
	);

	// ROM area starts 1 MB up, one 8k page per bank
	function automatic logic [24:0] rom_addr(input logic [6:0] bank, input logic [15:0] addr);
		rom_addr = 25'h100000 + {5'd0, bank, 13'd0} + {12'd0, addr[12:0]};
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic load_chunk(input logic [15:0] laddr, input logic [15:0] size,
			input logic [5:0] num, input logic [24:0] raddr);
		logic [6:0] page;
		page = raddr[19:13];
		@(posedge clk32);
		cart_chunk.laddr <= laddr;
		cart_chunk.size  <= size;
		cart_chunk.num   <= {10'd0, num};
		cart_chunk.raddr <= raddr;
		cart_bank_wr     <= 1'b1;
		if (laddr <= 16'h8000) begin
			lo_tab[num] = page;
			if (size > 16'h2000)
				hi_tab[num] = page + 7'd1;   // Upper 8k of a 16k chunk
		end else begin
			hi_tab[num] = page;
		end
	endtask

	task automatic set_loading(input logic level);
		@(posedge clk32);
		cart_bank_wr <= 1'b0;
		cart_loading <= level;
	endtask

	// Id change resets, then one init cycle, then normal operation
	task automatic select_type(input cart_pkg::cart_type_e id);
		@(posedge clk32);
		cart_id <= id;
		repeat (3) @(posedge clk32);
		@(negedge clk32);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		c64_bus_pkg::c64_bus_t b;
		b = '0;
		b.addr      = addr;
		b.data      = data;
		b.ioe       = addr[15:8] == 8'hDE;
		b.iof       = addr[15:8] == 8'hDF;
		b.mem_write = 1'b1;
		@(posedge clk32);
		bus <= b;
		@(posedge clk32);
		bus <= '0;
		@(negedge clk32);
	endtask

	// kind 0 is ROML read, 1 ROMH read, 2 Ultimax ROMH fetch, 3 ROML write
	task automatic bus_check(input string name, input int kind, input logic [15:0] addr);
		c64_bus_pkg::c64_bus_t b;
		logic [24:0] expected;
		b = '0;
		b.addr      = addr;
		b.roml      = kind == 0 || kind == 3;
		b.romh      = kind == 1;
		b.umax_romh = kind == 2;
		b.mem_write = kind == 3;
		b.mem_ce    = 1'($urandom());
		if (kind == 2)
			expected = rom_addr(m_hi, addr | 16'h1000);
		else if (m_exrom && m_game)
			expected = {9'd0, addr};          // No cart visible
		else
			expected = rom_addr(kind == 0 ? m_lo : m_hi, addr);
		@(posedge clk32);
		bus <= b;
		@(negedge clk32);
		check({name, " ce"}, 32'(b.mem_ce), 32'(mem_ce_out));
		if (kind == 3)
			check(name, 32'(!(m_exrom && !m_game)), 32'(mem_write_out));
		else
			check(name, 32'(expected), 32'(addr_out));
	endtask

	task automatic check_state(input string name);
		check({name, " exrom"}, 32'(m_exrom), 32'(exrom));
		check({name, " game"}, 32'(m_game), 32'(game));
		check({name, " bank_lo"}, 32'(m_lo), 32'(bank_lo));
		check({name, " bank_hi"}, 32'(m_hi), 32'(bank_hi));
		bus_check({name, " roml"}, 0, 16'h8000 | 16'($urandom() % 8192));
		bus_check({name, " romh"}, 1, 16'hA000 | 16'($urandom() % 8192));
		bus_check({name, " umax romh"}, 2, 16'hF000 | 16'($urandom() % 4096));
		bus_check({name, " write guard"}, 3, 16'h8000 | 16'($urandom() % 8192));
	endtask

	// IOF RAM access, chip enable only on the first cycle
	task automatic iof_check(input string name, input logic wr, input logic [7:0] lo);
		c64_bus_pkg::c64_bus_t b;
		b = '0;
		b.addr      = {8'hDF, lo};
		b.iof       = 1'b1;
		b.mem_write = wr;
		@(posedge clk32);
		bus <= b;
		@(negedge clk32);
		check({name, " iof addr"}, 32'h10000 | 32'(lo), 32'(addr_out));
		check({name, " iof ce"}, 32'd1, 32'(mem_ce_out));
		@(negedge clk32);
		check({name, " iof ce held"}, 32'd0, 32'(mem_ce_out));
		@(posedge clk32);
		bus <= '0;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk32);
		$display("Watchdog expired: the test did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$fatal(1, "Simulation timed out");
	end

	initial begin
		logic [7:0] data;
		void'($urandom(32'h96510595));
		cart_loading = 1'b0;
		cart_id      = cart_pkg::cart_type_e'(16'd7);   // Unsupported type
		cart_exrom   = 1'b1;
		cart_game    = 1'b1;
		cart_chunk   = '0;
		cart_bank_wr = 1'b0;
		bus          = '0;
		m_exrom = 1'b1;
		m_game  = 1'b1;
		m_lo    = '0;
		m_hi    = '0;
		wait (reset_n === 1'b0);
		@(posedge clk32);
		@(negedge clk32);
		check_state("no cart");

		// Every entry gets a page first, then random chunks overwrite some
		set_loading(1'b1);
		for (int i = 0; i < 64; i++)
			load_chunk(16'h8000, 16'h4000, 6'(i), 25'($urandom()));
		for (int i = 0; i < N_CHUNKS; i++)
			load_chunk(($urandom() % 2) ? 16'hA000 : 16'h8000,
				($urandom() % 2) ? 16'h4000 : 16'h2000, 6'($urandom()), 25'($urandom()));
		set_loading(1'b0);

		select_type(cart_pkg::CART_NORMAL);
		for (int i = 0; i < 4; i++) begin
			m_exrom = 1'($urandom());
			m_game  = 1'($urandom());
			@(posedge clk32);
			cart_exrom <= m_exrom;
			cart_game  <= m_game;
			repeat (2) @(posedge clk32);
			@(negedge clk32);
			m_lo = lo_tab[0];
			m_hi = hi_tab[0];
			check_state("normal");
		end

		select_type(cart_pkg::CART_OCEAN);
		m_exrom = 1'b0;
		m_game  = 1'b0;
		m_lo    = '0;
		m_hi    = '0;
		check_state("ocean start");
		for (int i = 0; i < N_IO; i++) begin
			data = 8'($urandom());
			io_write(16'hDE00 | 16'($urandom() % 256), data);
			m_lo = {1'b0, data[5:0]};
			m_hi = m_lo;
			check_state("ocean bank");
		end
		set_loading(1'b1);
		load_chunk(16'h8000, 16'h2000, 6'd32 | 6'($urandom() % 32), 25'($urandom()));
		set_loading(1'b0);
		repeat (2) @(posedge clk32);
		@(negedge clk32);
		m_game = 1'b1;            // 512k image seen
		check_state("ocean 512k");

		select_type(cart_pkg::CART_MAGIC_DESK);
		m_exrom = 1'b0;
		m_game  = 1'b1;
		m_lo    = '0;
		m_hi    = '0;
		check_state("magic desk start");
		for (int i = 0; i < N_IO; i++) begin
			data = 8'($urandom());
			io_write(16'hDE00 | 16'($urandom() % 256), data);
			m_lo    = {3'd0, data[3:0]};
			m_exrom = data[7];
			check_state("magic desk bank");
		end

		// **************************************************
		// EasyFlash and XBank
		// **************************************************
		for (int k = 0; k < 2; k++) begin
			select_type(k == 0 ? cart_pkg::CART_EASYFLASH : cart_pkg::CART_XBANK);
			m_exrom = k == 0;
			m_game  = 1'b0;
			m_lo    = lo_tab[0];
			m_hi    = hi_tab[0];
			check_state("easyflash start");
			for (int i = 0; i < N_IO; i++) begin
				data = 8'($urandom());
				if ($urandom() % 2) begin
					io_write(16'hDE02, data);
					m_game  = ~data[0] & data[2];
					m_exrom = ~data[1];
				end else begin
					io_write(16'hDE00, data);
					m_lo = lo_tab[data[5:0]];
					m_hi = hi_tab[data[5:0]];
				end
				check_state("easyflash reg");
				iof_check("easyflash", 1'($urandom()), 8'($urandom()));
			end
			io_write(16'hDE02, 8'h00);   // Ultimax
			m_exrom = 1'b1;
			m_game  = 1'b0;
			check_state("easyflash ultimax");
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* test/tb_clock.sv */
// Clock and reset generator for the cartridge testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int RESET_CYCLES = 3
) (
	output logic clk32,
	output logic reset_n       // High while reset is applied
);
	initial begin
		clk32 = 1'b0;
		forever #5 clk32 = ~clk32;   // 10 ns period
	end

	initial begin
		reset_n = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk32);
		reset_n <= 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/cartridge.sv */
// Cartridge top level with bank table, IO decoder, control registers and translator
`timescale 1ns/1ps
`default_nettype none

module cartridge #(
	parameter int BANK_SLOTS = 64
) (
	input  logic                     clk32,
	input  logic                     reset_n,
	input  logic                     cart_loading,
	input  cart_pkg::cart_type_e     cart_id,
	input  logic                     cart_exrom,
	input  logic                     cart_game,
	input  cart_pkg::cart_chunk_t    cart_chunk,
	input  logic                     cart_bank_wr,
	input  c64_bus_pkg::c64_bus_t    bus,
	output logic                     exrom,
	output logic                     game,
	output logic                     mem_ce_out,
	output logic                     mem_write_out,
	output c64_bus_pkg::sdram_addr_t addr_out,
	output cart_pkg::bank_t          bank_lo,
	output cart_pkg::bank_t          bank_hi
);
	logic [5:0]      lookup_idx;
	cart_pkg::bank_t lo_page;
	cart_pkg::bank_t hi_page;
	logic            ioe_wr;
	logic            ioe_rd;
	logic            iof_cs;
	logic            iof_ena;
	logic            iof_wr_ena;

	cart_bank_table #(.BANK_SLOTS(BANK_SLOTS)) u_table (
		.clk32(clk32), .cart_loading(cart_loading), .cart_bank_wr(cart_bank_wr),
		.cart_chunk(cart_chunk), .lookup_idx(lookup_idx),
		.lo_page(lo_page), .hi_page(hi_page), .chunk_count()
	);

	cart_io_decode u_io (
		.clk32(clk32), .bus(bus), .ioe_wr(ioe_wr), .ioe_rd(ioe_rd), .iof_wr(),
		.iof_cs(iof_cs), .iof_ena(iof_ena), .iof_wr_ena(iof_wr_ena), .mem_ce_out(mem_ce_out)
	);

	cart_ctrl_regs #(.BANK_SLOTS(BANK_SLOTS)) u_ctrl (
		.clk32(clk32), .reset_n(reset_n), .cart_id(cart_id),
		.cart_exrom(cart_exrom), .cart_game(cart_game),
		.cart_bank_wr(cart_bank_wr), .chunk_num(cart_chunk.num), .bus(bus),
		.ioe_wr(ioe_wr), .ioe_rd(ioe_rd), .lookup_idx(lookup_idx),
		.lo_page(lo_page), .hi_page(hi_page), .exrom(exrom), .game(game),
		.bank_lo(bank_lo), .bank_hi(bank_hi), .iof_ena(iof_ena), .iof_wr_ena(iof_wr_ena)
	);

	cart_addr_xlate u_xlate (
		.reset_n(reset_n), .bus(bus), .bank_lo(bank_lo), .bank_hi(bank_hi),
		.exrom(exrom), .game(game), .iof_cs(iof_cs), .iof_wr_ena(iof_wr_ena),
		.addr_out(addr_out), .mem_write_out(mem_write_out)
	);

endmodule

`default_nettype wire

/* verilog/cart_addr_xlate.sv */
// CPU to SDRAM address translation for ROML, ROMH, IOF and Ultimax fetches, write guard
`timescale 1ns/1ps
`default_nettype none

module cart_addr_xlate (
	input  logic                     reset_n,
	input  c64_bus_pkg::c64_bus_t    bus,
	input  cart_pkg::bank_t          bank_lo,
	input  cart_pkg::bank_t          bank_hi,
	input  logic                     exrom,
	input  logic                     game,
	input  logic                     iof_cs,
	input  logic                     iof_wr_ena,
	output c64_bus_pkg::sdram_addr_t addr_out,
	output logic                     mem_write_out
);
	logic cart_on;
	logic ultimax;

	function automatic c64_bus_pkg::page_t rom_page(input cart_pkg::bank_t bank);
		rom_page = c64_bus_pkg::ROM_PAGE_BASE | c64_bus_pkg::page_t'(bank);
	endfunction

	assign cart_on = !reset_n && !(exrom && game);   // Both high means no cart visible
	assign ultimax = exrom && !game;

	// Ultimax has no RAM under ROML
	assign mem_write_out = bus.mem_write & ~(bus.roml & ultimax);

	always_comb begin
		addr_out = c64_bus_pkg::sdram_addr_t'(bus.addr);
		if (cart_on) begin
			if (bus.romh && !bus.mem_write)
				addr_out = {rom_page(bank_hi), bus.addr[12:0]};
			if (bus.roml && !bus.mem_write)
				addr_out = {rom_page(bank_lo), bus.addr[12:0]};
		end

		// **************************************************
		// IOF window and VIC character fetches
		// **************************************************
		if (iof_cs) begin
			if (iof_wr_ena)
				addr_out = {c64_bus_pkg::RAM_PAGE_BASE, 5'd0, bus.addr[7:0]};   // 256 byte RAM
			else
				addr_out = {rom_page(bank_lo), bus.addr[12:0]};
		end

		if (bus.umax_romh)
			addr_out = {rom_page(bank_hi), 1'b1, bus.addr[11:0]};   // Upper 4k of ROMH
	end

endmodule

`default_nettype wire

/* verilog/cart_ctrl_regs.sv */
// Per-type control FSM for EXROM, GAME, bank numbers and IOF enables
`timescale 1ns/1ps
`default_nettype none

module cart_ctrl_regs #(
	parameter int BANK_SLOTS = 64
) (
	input  logic                  clk32,
	input  logic                  reset_n,
	input  cart_pkg::cart_type_e  cart_id,
	input  logic                  cart_exrom,
	input  logic                  cart_game,
	input  logic                  cart_bank_wr,
	input  logic [15:0]           chunk_num,
	input  c64_bus_pkg::c64_bus_t bus,
	input  logic                  ioe_wr,
	input  logic                  ioe_rd,
	output logic [5:0]            lookup_idx,
	input  cart_pkg::bank_t       lo_page,
	input  cart_pkg::bank_t       hi_page,
	output logic                  exrom,
	output logic                  game,
	output cart_pkg::bank_t       bank_lo,
	output cart_pkg::bank_t       bank_hi,
	output logic                  iof_ena,
	output logic                  iof_wr_ena
);
	localparam logic [5:0] IDX_MASK = 6'(BANK_SLOTS - 1);  // Bank numbers wrap on small tables

	cart_pkg::cart_type_e old_id;
	logic init_done;
	logic ocean_big;
	logic id_change;
	logic is_ef;
	logic ef_bank_sel;

	assign id_change   = cart_id != old_id;
	assign is_ef       = (cart_id == cart_pkg::CART_EASYFLASH) || (cart_id == cart_pkg::CART_XBANK);
	assign ef_bank_sel = is_ef && init_done && ioe_wr && !bus.addr[1];   // $DE00 write
	assign lookup_idx  = ef_bank_sel ? (bus.data[5:0] & IDX_MASK) : 6'd0;

	// Ocean type B, 512k with ROML only
	always_ff @(posedge clk32) begin
		if (cart_bank_wr && chunk_num >= cart_pkg::OCEAN_B_MIN_NUM)
			ocean_big <= 1'b1;
		else if (reset_n || id_change)
			ocean_big <= 1'b0;
	end

	// **************************************************
	// Type dependent register updates
	// **************************************************
	always_ff @(posedge clk32) begin
		old_id <= cart_id;
		if (reset_n || id_change) begin
			exrom      <= 1'b1;
			game       <= 1'b1;
			bank_lo    <= '0;
			bank_hi    <= '0;
			iof_ena    <= 1'b0;
			iof_wr_ena <= 1'b0;
			init_done  <= 1'b0;
		end else begin
			init_done <= 1'b1;
			case (cart_id)
				cart_pkg::CART_NORMAL: begin
					exrom   <= cart_exrom;     // Straight from the CRT header
					game    <= cart_game;
					bank_lo <= lo_page;
					bank_hi <= hi_page;
				end
				cart_pkg::CART_OCEAN: begin
					exrom <= 1'b0;
					game  <= ocean_big;
					if (ioe_wr) begin
						bank_lo <= {1'b0, bus.data[5:0]};   // Same bank at $8000 and $A000
						bank_hi <= {1'b0, bus.data[5:0]};
					end
				end
				cart_pkg::CART_MAGIC_DESK: begin
					if (!init_done) begin
						exrom   <= 1'b0;
						game    <= 1'b1;
						bank_lo <= '0;
					end else if (ioe_wr) begin
						bank_lo <= {3'b000, bus.data[3:0]};
						exrom   <= bus.data[7];         // Bit 7 hides the cart
					end
				end
				cart_pkg::CART_EASYFLASH, cart_pkg::CART_XBANK: begin
					if (!init_done) begin
						// EasyFlash boots in Ultimax, XBank in 16k
						exrom      <= cart_id == cart_pkg::CART_EASYFLASH;
						game       <= 1'b0;
						iof_ena    <= 1'b1;
						iof_wr_ena <= 1'b1;
						bank_lo    <= lo_page;
						bank_hi    <= hi_page;
					end else if (ioe_wr) begin
						if (bus.addr[1]) begin
							game  <= ~bus.data[0] & bus.data[2];  // Boot jumper assumed
							exrom <= ~bus.data[1];
						end else begin
							bank_lo <= lo_page;
							bank_hi <= hi_page;
						end
					end
				end
				default: begin
					exrom <= 1'b1;                    // No cartridge
					game  <= 1'b1;
				end
			endcase
		end
	end

	a_reset_lines : assert property (@(posedge clk32) reset_n |=> exrom && game);

	// IOE reads never switch banks in the kept types
	a_rd_no_switch : assert property (@(posedge clk32) disable iff (reset_n)
		ioe_rd && init_done && $stable(cart_id) && cart_id != cart_pkg::CART_NORMAL
		|=> $stable(bank_lo) && $stable(bank_hi));

endmodule

`default_nettype wire

/* verilog/cart_io_decode.sv */
// IOE and IOF edge strobes, read and write split, IOF chip select and chip enable
`timescale 1ns/1ps
`default_nettype none

module cart_io_decode (
	input  logic                  clk32,
	input  c64_bus_pkg::c64_bus_t bus,
	output logic                  ioe_wr,
	output logic                  ioe_rd,
	output logic                  iof_wr,
	output logic                  iof_cs,
	input  logic                  iof_ena,
	input  logic                  iof_wr_ena,
	output logic                  mem_ce_out
);
	logic ioe_q;
	logic iof_q;
	logic ioe_stb;
	logic iof_stb;
	logic iof_rd;

	always_ff @(posedge clk32) begin
		ioe_q <= bus.ioe;
		iof_q <= bus.iof;
	end

	// First cycle of each IO access
	assign ioe_stb = bus.ioe & ~ioe_q;
	assign iof_stb = bus.iof & ~iof_q;

	assign ioe_wr = ioe_stb & bus.mem_write;
	assign ioe_rd = ioe_stb & ~bus.mem_write;
	assign iof_wr = iof_stb & bus.mem_write;
	assign iof_rd = iof_stb & ~bus.mem_write;

	assign iof_cs = bus.iof & (bus.mem_write ? iof_wr_ena : iof_ena);

	// SDRAM access for the IOF RAM starts on the strobe
	assign mem_ce_out = bus.mem_ce | (iof_cs & (iof_wr | iof_rd));

	// IOE and IOF are separate address windows, never selected together
	a_io_exclusive : assert property (@(posedge clk32) !(bus.ioe && bus.iof));

endmodule

`default_nettype wire

/* verilog/cart_bank_table.sv */
// Per-bank SDRAM page table filled from CRT chunks, lookup port and chunk counter
`timescale 1ns/1ps
`default_nettype none

module cart_bank_table #(
	parameter int BANK_SLOTS = 64
) (
	input  logic                  clk32,
	input  logic                  cart_loading,
	input  logic                  cart_bank_wr,
	input  cart_pkg::cart_chunk_t cart_chunk,
	input  logic [5:0]            lookup_idx,
	output cart_pkg::bank_t       lo_page,
	output cart_pkg::bank_t       hi_page,
	output logic [7:0]            chunk_count
);
	localparam int IDX_W = $clog2(BANK_SLOTS);

	cart_pkg::bank_t lo_mem [BANK_SLOTS];
	cart_pkg::bank_t hi_mem [BANK_SLOTS];

	cart_pkg::bank_t  chunk_page;
	logic [IDX_W-1:0] wr_idx;
	logic             slot_ok;
	logic             loading_q;
	logic             load_rise;

	assign chunk_page = cart_chunk.raddr[cart_pkg::CHUNK_BANK_SHIFT +: $bits(cart_pkg::bank_t)];
	assign wr_idx     = cart_chunk.num[IDX_W-1:0];
	assign slot_ok    = 32'(cart_chunk.num) < BANK_SLOTS;  // Higher banks are dropped
	assign load_rise  = cart_loading & ~loading_q;

	always_ff @(posedge clk32) begin
		if (cart_bank_wr && slot_ok) begin
			if (cart_chunk.laddr <= cart_pkg::LOAD_HI_BOUND) begin
				lo_mem[wr_idx] <= chunk_page;
				// 16k chunk, upper half belongs to ROMH
				if (cart_chunk.size > cart_pkg::BANK_16K)
					hi_mem[wr_idx] <= chunk_page + 7'd1;
			end else begin
				hi_mem[wr_idx] <= chunk_page;
			end
		end
	end

	always_ff @(posedge clk32) begin
		loading_q <= cart_loading;
		if (load_rise || cart_bank_wr)
			chunk_count <= (load_rise ? 8'd0 : chunk_count) + {7'd0, cart_bank_wr};
	end

	assign lo_page = (32'(lookup_idx) < BANK_SLOTS) ? lo_mem[lookup_idx] : '0;
	assign hi_page = (32'(lookup_idx) < BANK_SLOTS) ? hi_mem[lookup_idx] : '0;

	// Loader only hands out chunks inside a load window
	a_wr_in_load : assert property (@(posedge clk32) cart_bank_wr |-> cart_loading);

endmodule

`default_nettype wire

/* verilog/c64_bus_pkg.sv */
// Expansion port request struct, SDRAM address and page types, ROM and RAM page bases
`default_nettype none

package c64_bus_pkg;

	localparam int SDRAM_AW = 25;
	localparam int PAGE_LSB = 13;   // 8k pages

	typedef logic [SDRAM_AW-1:0]        sdram_addr_t;
	typedef logic [SDRAM_AW-PAGE_LSB-1:0] page_t;

	// ROM pages sit at 0x100000, marker bit is address bit 20
	localparam page_t ROM_PAGE_BASE = 12'h080;
	// RAM pages sit at 0x010000, only 8 of them
	localparam page_t RAM_PAGE_BASE = 12'h008;

	// CPU side of the cartridge port, sampled every clk32
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        roml;
		logic        romh;
		logic        umax_romh;    // VIC fetch of ROMH in Ultimax mode
		logic        ioe;          // $DE00-$DEFF
		logic        iof;          // $DF00-$DFFF
		logic        mem_write;
		logic        mem_ce;
	} c64_bus_t;

endpackage

`default_nettype wire

/* verilog/cart_pkg.sv */
// Cartridge type ids, bank number type, CRT chunk header struct and load limits
`default_nettype none

package cart_pkg;

	// Kept hardware types, same numbering as the CRT header
	typedef enum logic [15:0] {
		CART_NORMAL     = 16'd0,   // 8k, 16k or Ultimax
		CART_OCEAN      = 16'd5,
		CART_MAGIC_DESK = 16'd19,
		CART_EASYFLASH  = 16'd32,
		CART_XBANK      = 16'd33
	} cart_type_e;

	typedef logic [6:0] bank_t;    // 8k page number inside the ROM area

	// 8k page number starts at this bit of the chunk SDRAM address
	localparam int CHUNK_BANK_SHIFT = 13;

	localparam logic [15:0] LOAD_HI_BOUND   = 16'h8000;  // At or below is ROML
	localparam logic [15:0] BANK_16K        = 16'h2000;  // Larger chunks spill into ROMH
	localparam logic [15:0] OCEAN_B_MIN_NUM = 16'd32;    // 512k Ocean images go past bank 31

	// One CRT CHIP packet as handed over by the loader
	typedef struct packed {
		logic [15:0] laddr;        // C64 load address
		logic [15:0] size;         // Image size in bytes
		logic [15:0] num;          // Bank number
		logic [24:0] raddr;        // Where the loader put it in SDRAM
	} cart_chunk_t;

endpackage

`default_nettype wire
